//--- prci_subsys.f
logic/prci_cfg_pkg.sv
logic/prci_apb_pkg.sv
logic/prci_lock_filter.sv
logic/prci_reset_seq.sv
logic/prci_apb_regs.sv
logic/prci_top.sv
dv/prci_tb.sv

//--- Bender.yml
package:
  name: prci_subsys

sources:
  # Packages first, then the stages and the top level
  - logic/prci_cfg_pkg.sv
  - logic/prci_apb_pkg.sv
  - logic/prci_lock_filter.sv
  - logic/prci_reset_seq.sv
  - logic/prci_apb_regs.sv
  - logic/prci_top.sv
  - target: simulation
    files:
      - dv/prci_tb.sv

//--- dv/prci_tb.sv
// Assumes filter and hold lengths of 8 and 16 cycles and an APB slave without wait states
`timescale 1ns/100ps

module prci_tb;

  import prci_apb_pkg::*;

  localparam int LOCK_FILTER = 8;
  localparam int RESET_HOLD  = 16;
  localparam int WAIT_LIMIT  = 200;
  localparam int APB_LIMIT   = 8;
  // Release latencies counted in clock edges from the lock input rise
  localparam int LOCK_TO_DBG = 2 + LOCK_FILTER + 1;
  localparam int LOCK_TO_SYS = 2 + LOCK_FILTER + RESET_HOLD + 1;

  logic      i_clk;
  logic      i_reset;
  logic      i_sys_locked;
  logic      i_ddr_locked;
  logic      i_dmi_reset;
  logic      i_psel;
  logic      i_penable;
  logic      i_pwrite;
  apb_addr_t i_paddr;
  apb_data_t i_pwdata;
  logic      o_sys_nrst;
  logic      o_dbg_nrst;
  apb_data_t o_prdata;
  logic      o_pready;
  logic      o_pslverr;
  integer    seed;
  logic      dbg_hold;

  prci_top #(
    .LOCK_FILTER(LOCK_FILTER),
    .RESET_HOLD (RESET_HOLD)
  ) u_dut (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_sys_locked (i_sys_locked),
    .i_ddr_locked (i_ddr_locked),
    .i_dmi_reset  (i_dmi_reset),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_sys_nrst   (o_sys_nrst),
    .o_dbg_nrst   (o_dbg_nrst),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;

  task automatic abort_run(input string what);
    $display("[ERROR] %s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string test, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s expected 0x%0h actual 0x%0h", test, exp, act);
    $display("Checks failed");
    $fatal(1);
  endtask

  // Debug reset released first and kept released through system reset events
  always @(negedge i_clk) begin
    if (!i_reset) begin
      assert (o_dbg_nrst || !o_sys_nrst)
        else abort_run("system reset released while debug reset is asserted");
      if (dbg_hold) begin
        assert (o_dbg_nrst) else abort_run("debug reset asserted during a system reset event");
      end
    end
  end

  function automatic logic level_of(input int sel);
    return (sel == 0) ? o_sys_nrst : o_dbg_nrst;
  endfunction

  // Sel 0 watches the system reset and sel 1 the debug reset
  task automatic wait_for_level(input int sel, input logic level, input string what,
                                output int cycles);
    cycles = 0;
    while (level_of(sel) !== level) begin
      if (cycles == WAIT_LIMIT) begin
        abort_run($sformatf("timed out waiting for %s, sequencer state %0d", what,
                            u_dut.u_reset_seq.state));
      end
      @(negedge i_clk);
      cycles++;
    end
  endtask

  task automatic check_idle(input int n, input logic sys_exp, input logic dbg_exp,
                            input string test);
    repeat (n) begin
      @(negedge i_clk);
      assert (o_sys_nrst === sys_exp) else value_mismatch({test, "_sys"}, sys_exp, o_sys_nrst);
      assert (o_dbg_nrst === dbg_exp) else value_mismatch({test, "_dbg"}, dbg_exp, o_dbg_nrst);
    end
  endtask

  // Access phase sampled just before the completing edge
  task automatic finish_access(output apb_data_t data, output logic err);
    int n;
    @(negedge i_clk);
    i_penable = 1'b1;
    #1;
    n = 0;
    while (o_pready !== 1'b1) begin
      if (n == APB_LIMIT) abort_run("APB slave never raised PREADY");
      @(negedge i_clk);
      #1;
      n++;
    end
    assert (n == 0) else value_mismatch("apb_wait_states", 0, n);
    data = o_prdata;
    err  = o_pslverr;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge i_clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b0;
    i_paddr  = addr;
    finish_access(data, err);
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    @(negedge i_clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b1;
    i_paddr  = addr;
    i_pwdata = data;
    finish_access(unused, err);
  endtask

  initial begin : stimulus
    apb_data_t rdata;
    apb_data_t st_before;
    apb_data_t ll_before;
    logic      err;
    int        cycles;
    int        glitch_len;
    seed         = 32'hef950662;
    dbg_hold     = 1'b0;
    i_reset      = 1'b1;
    i_sys_locked = 1'b0;
    i_ddr_locked = 1'b0;
    i_dmi_reset  = 1'b0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_pwrite     = 1'b0;
    i_paddr      = '0;
    i_pwdata     = '0;
    repeat (16) @(negedge i_clk);
    i_reset = 1'b0;
    assert ({o_pslverr, o_dbg_nrst, o_sys_nrst} === 3'b000)
      else value_mismatch("after_reset", 0, {o_pslverr, o_dbg_nrst, o_sys_nrst});
    assert (o_prdata === '0) else value_mismatch("after_reset_prdata", 0, o_prdata);
    check_idle(30, 1'b0, 1'b0, "no_lock");

    // Short sys lock glitch with the status read while the synchronized level is high
    glitch_len   = 3 + ($unsigned($random(seed)) % (LOCK_FILTER - 3));
    i_sys_locked = 1'b1;
    apb_read(REG_STATUS, rdata, err);
    assert (rdata[0] === 1'b0) else value_mismatch("glitch_status", 0, rdata);
    assert (err === 1'b0) else value_mismatch("glitch_status_err", 0, err);
    repeat (glitch_len - 3) @(negedge i_clk);
    i_sys_locked = 1'b0;
    check_idle(LOCK_TO_DBG + 4, 1'b0, 1'b0, "glitch");

    // Ordered release with DDR lock later
    i_sys_locked = 1'b1;
    wait_for_level(1, 1'b1, "debug reset release", cycles);
    assert (cycles == LOCK_TO_DBG) else value_mismatch("dbg_release", LOCK_TO_DBG, cycles);
    check_idle(5, 1'b0, 1'b1, "wait_ddr");
    apb_read(REG_STATUS, rdata, err);
    assert (rdata === 32'h9) else value_mismatch("wait_ddr_status", 32'h9, rdata);
    assert (err === 1'b0) else value_mismatch("wait_ddr_status_err", 0, err);
    i_ddr_locked = 1'b1;
    wait_for_level(0, 1'b1, "system reset release", cycles);
    assert (cycles == LOCK_TO_SYS) else value_mismatch("sys_release", LOCK_TO_SYS, cycles);
    dbg_hold = 1'b1;

    // DDR lock loss in run
    apb_read(REG_LOCK_LOSS, ll_before, err);
    i_ddr_locked = 1'b0;
    wait_for_level(0, 1'b0, "system reset on DDR loss", cycles);
    assert (cycles <= 3) else value_mismatch("ddr_loss_drop", 3, cycles);
    apb_read(REG_LOCK_LOSS, rdata, err);
    assert (rdata === ll_before + 1) else value_mismatch("lock_loss_count", ll_before + 1, rdata);
    assert (err === 1'b0) else value_mismatch("lock_loss_err", 0, err);
    check_idle(4, 1'b0, 1'b1, "ddr_loss_hold");
    i_ddr_locked = 1'b1;
    wait_for_level(0, 1'b1, "system reset after DDR relock", cycles);
    assert (cycles == LOCK_TO_SYS) else value_mismatch("ddr_relock", LOCK_TO_SYS, cycles);

    // Software request, then debug-module request
    apb_write(REG_RESET_REQ, 32'h1, err);
    assert (err === 1'b0) else value_mismatch("sw_req_err", 0, err);
    wait_for_level(0, 1'b0, "system reset on software request", cycles);
    assert (cycles == 1) else value_mismatch("sw_req_drop", 1, cycles);
    wait_for_level(0, 1'b1, "system reset after software request", cycles);
    assert (cycles == RESET_HOLD) else value_mismatch("sw_req_release", RESET_HOLD, cycles);
    apb_read(REG_STATUS, rdata, err);
    assert (rdata === 32'hF) else value_mismatch("sw_req_status", 32'hF, rdata);
    i_dmi_reset = 1'b1;
    @(negedge i_clk);
    i_dmi_reset = 1'b0;
    assert (o_sys_nrst === 1'b0) else value_mismatch("dmi_drop", 0, o_sys_nrst);
    wait_for_level(0, 1'b1, "system reset after debug-module request", cycles);
    assert (cycles == RESET_HOLD) else value_mismatch("dmi_release", RESET_HOLD, cycles);
    apb_read(REG_STATUS, rdata, err);
    assert (rdata === 32'hF) else value_mismatch("dmi_status", 32'hF, rdata);

    // Unmapped offset
    apb_read(REG_STATUS, st_before, err);
    apb_read(REG_LOCK_LOSS, ll_before, err);
    apb_read(12'h00C, rdata, err);
    assert (rdata === '0) else value_mismatch("unmapped_rdata", 0, rdata);
    assert (err === 1'b1) else value_mismatch("unmapped_read_err", 1, err);
    apb_write(12'h00C, 32'hFFFF_FFFF, err);
    assert (err === 1'b1) else value_mismatch("unmapped_write_err", 1, err);
    check_idle(4, 1'b1, 1'b1, "unmapped_write");
    apb_read(REG_STATUS, rdata, err);
    assert (rdata === st_before) else value_mismatch("unmapped_status", st_before, rdata);
    apb_read(REG_LOCK_LOSS, rdata, err);
    assert (rdata === ll_before) else value_mismatch("unmapped_lock_loss", ll_before, rdata);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- logic/prci_top.sv
// Single clock domain; lock inputs may be asynchronous but i_dmi_reset must be synchronous to i_clk
`timescale 1ns/100ps

module prci_top #(
  parameter prci_cfg_pkg::prci_cnt_t LOCK_FILTER = prci_cfg_pkg::DEF_LOCK_FILTER,
  parameter prci_cfg_pkg::prci_cnt_t RESET_HOLD  = prci_cfg_pkg::DEF_RESET_HOLD
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_sys_locked,
  input  logic                    i_ddr_locked,
  input  logic                    i_dmi_reset,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  prci_apb_pkg::apb_addr_t i_paddr,
  input  prci_apb_pkg::apb_data_t i_pwdata,
  output logic                    o_sys_nrst,
  output logic                    o_dbg_nrst,
  output prci_apb_pkg::apb_data_t o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr
);

  logic w_sys_ok;
  logic w_ddr_ok;
  logic w_sw_reset_req;
  logic w_lock_lost;

  // Lock qualification
  prci_lock_filter #(
    .LOCK_FILTER(LOCK_FILTER)
  ) u_lock_filter (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_sys_locked (i_sys_locked),
    .i_ddr_locked (i_ddr_locked),
    .o_sys_ok     (w_sys_ok),
    .o_ddr_ok     (w_ddr_ok)
  );

  // Reset ordering
  prci_reset_seq #(
    .RESET_HOLD(RESET_HOLD)
  ) u_reset_seq (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_sys_ok       (w_sys_ok),
    .i_ddr_ok       (w_ddr_ok),
    .i_sw_reset_req (w_sw_reset_req),
    .i_dmi_reset    (i_dmi_reset),
    .o_sys_nrst     (o_sys_nrst),
    .o_dbg_nrst     (o_dbg_nrst),
    .o_lock_lost    (w_lock_lost)
  );

  // Register access, also reads back the reset outputs
  prci_apb_regs u_apb_regs (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .i_sys_ok       (w_sys_ok),
    .i_ddr_ok       (w_ddr_ok),
    .i_sys_nrst     (o_sys_nrst),
    .i_dbg_nrst     (o_dbg_nrst),
    .i_lock_lost    (w_lock_lost),
    .o_prdata       (o_prdata),
    .o_pready       (o_pready),
    .o_pslverr      (o_pslverr),
    .o_sw_reset_req (w_sw_reset_req)
  );

endmodule

//--- logic/prci_apb_regs.sv
// Zero-wait-state APB slave; unmapped offsets answer with PSLVERR and writes to read-only registers are dropped
`timescale 1ns/100ps

module prci_apb_regs (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  prci_apb_pkg::apb_addr_t i_paddr,
  input  prci_apb_pkg::apb_data_t i_pwdata,
  input  logic                    i_sys_ok,
  input  logic                    i_ddr_ok,
  input  logic                    i_sys_nrst,
  input  logic                    i_dbg_nrst,
  input  logic                    i_lock_lost,
  output prci_apb_pkg::apb_data_t o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  output logic                    o_sw_reset_req
);

  import prci_apb_pkg::*;

  logic      access;
  logic      hit_status;
  logic      hit_reset_req;
  logic      hit_lock_loss;
  logic      hit_any;
  apb_data_t status_word;
  apb_data_t lock_loss_cnt;
  apb_data_t rd_mux;

  // Access phase of a transfer
  assign access = i_psel & i_penable;

  assign hit_status    = (i_paddr == REG_STATUS);
  assign hit_reset_req = (i_paddr == REG_RESET_REQ);
  assign hit_lock_loss = (i_paddr == REG_LOCK_LOSS);
  assign hit_any       = hit_status | hit_reset_req | hit_lock_loss;

  assign status_word = {{(APB_DATA_W-4){1'b0}}, i_dbg_nrst, i_sys_nrst, i_ddr_ok, i_sys_ok};

  always_comb begin
    rd_mux = '0;
    if (hit_status) begin
      rd_mux = status_word;
    end else if (hit_lock_loss) begin
      rd_mux = lock_loss_cnt;
    end
  end

  // No wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = access & ~hit_any;
  assign o_prdata  = (access && !i_pwrite) ? rd_mux : '0;

  // One-cycle request pulse after the access cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_sw_reset_req <= 1'b0;
    end else begin
      o_sw_reset_req <= access & i_pwrite & hit_reset_req & i_pwdata[0];
    end
  end

  // Lock losses in run, saturating
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      lock_loss_cnt <= '0;
    end else if (i_lock_lost && (lock_loss_cnt != '1)) begin
      lock_loss_cnt <= lock_loss_cnt + apb_data_t'(1);
    end
  end

endmodule

//--- logic/prci_reset_seq.sv
// Releases debug reset before system reset; RESET_HOLD must be at least 1 and requests outside ST_RUN or ST_HOLD are ignored
`timescale 1ns/100ps

module prci_reset_seq #(
  parameter prci_cfg_pkg::prci_cnt_t RESET_HOLD = prci_cfg_pkg::DEF_RESET_HOLD
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_sys_ok,
  input  logic i_ddr_ok,
  input  logic i_sw_reset_req,
  input  logic i_dmi_reset,
  output logic o_sys_nrst,
  output logic o_dbg_nrst,
  output logic o_lock_lost
);

  import prci_cfg_pkg::*;

  prci_state_e state;
  prci_cnt_t   hold_cnt;
  logic        reset_req;

  // Software and debug-module requests are handled the same way
  assign reset_req = i_sw_reset_req | i_dmi_reset;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state       <= ST_WAIT_SYS;
      hold_cnt    <= '0;
      o_sys_nrst  <= 1'b0;
      o_dbg_nrst  <= 1'b0;
      o_lock_lost <= 1'b0;
    end else begin
      o_lock_lost <= 1'b0;
      case (state)
        ST_WAIT_SYS: begin
          // Debug logic only needs the system clock
          if (i_sys_ok) begin
            o_dbg_nrst <= 1'b1;
            hold_cnt   <= '0;
            state      <= i_ddr_ok ? ST_HOLD : ST_WAIT_DDR;
          end
        end
        ST_WAIT_DDR: begin
          if (!i_sys_ok) begin
            o_dbg_nrst <= 1'b0;
            state      <= ST_WAIT_SYS;
          end else if (i_ddr_ok) begin
            hold_cnt <= '0;
            state    <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (!i_sys_ok) begin
            o_dbg_nrst <= 1'b0;
            state      <= ST_WAIT_SYS;
          end else if (!i_ddr_ok) begin
            state <= ST_WAIT_DDR;
          end else if (reset_req) begin
            hold_cnt <= '0;
          end else if (hold_cnt == RESET_HOLD - prci_cnt_t'(1)) begin
            o_sys_nrst <= 1'b1;
            state      <= ST_RUN;
          end else begin
            hold_cnt <= hold_cnt + prci_cnt_t'(1);
          end
        end
        ST_RUN: begin
          if (!i_sys_ok) begin
            o_sys_nrst  <= 1'b0;
            o_dbg_nrst  <= 1'b0;
            o_lock_lost <= 1'b1;
            state       <= ST_WAIT_SYS;
          end else if (!i_ddr_ok) begin
            o_sys_nrst  <= 1'b0;
            o_lock_lost <= 1'b1;
            state       <= ST_WAIT_DDR;
          end else if (reset_req) begin
            // Debug reset stays released across a request
            o_sys_nrst <= 1'b0;
            hold_cnt   <= '0;
            state      <= ST_HOLD;
          end
        end
        default: begin
          state <= ST_WAIT_SYS;
        end
      endcase
    end
  end

endmodule

//--- logic/prci_lock_filter.sv
// Lock inputs are asynchronous levels; two-flop synchronizers add 2 cycles of latency in both directions
`timescale 1ns/100ps

module prci_lock_filter #(
  parameter prci_cfg_pkg::prci_cnt_t LOCK_FILTER = prci_cfg_pkg::DEF_LOCK_FILTER
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_sys_locked,
  input  logic i_ddr_locked,
  output logic o_sys_ok,
  output logic o_ddr_ok
);

  import prci_cfg_pkg::*;

  // Index 0 is the system PLL lock, index 1 the DDR calibration flag
  logic [1:0] lock_in;
  logic [1:0] sync_meta;
  logic [1:0] sync_lvl;
  logic [1:0] stable;
  prci_cnt_t  stab_cnt [2];

  assign lock_in = {i_ddr_locked, i_sys_locked};

  // Two-flop synchronizer per input
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      sync_meta <= '0;
      sync_lvl  <= '0;
    end else begin
      sync_meta <= lock_in;
      sync_lvl  <= sync_meta;
    end
  end

  // Stability counters, saturate at the window length
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (i_reset || !sync_lvl[i]) begin
        stab_cnt[i] <= '0;
      end else if (stab_cnt[i] != LOCK_FILTER) begin
        stab_cnt[i] <= stab_cnt[i] + prci_cnt_t'(1);
      end
    end
  end

  // A low synchronized level drops the qualified lock without waiting for the counter
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      stable[i] = sync_lvl[i] && (stab_cnt[i] == LOCK_FILTER);
    end
  end

  assign o_sys_ok = stable[0];
  assign o_ddr_ok = stable[1];

endmodule

//--- logic/prci_apb_pkg.sv
// Register map of the PRCI APB slave; only full 12-bit offsets are decoded and byte strobes are not supported
package prci_apb_pkg;

  // Bus widths
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Read-only status
  // bit 0 sys lock ok, bit 1 ddr lock ok, bit 2 sys reset released, bit 3 dbg reset released
  localparam apb_addr_t REG_STATUS = apb_addr_t'(12'h000);

  // Write bit 0 to request a system reset, reads as zero
  localparam apb_addr_t REG_RESET_REQ = apb_addr_t'(12'h004);

  // Saturating lock-loss counter, cleared by i_reset only
  localparam apb_addr_t REG_LOCK_LOSS = apb_addr_t'(12'h008);

endpackage

//--- logic/prci_cfg_pkg.sv
// Sequencer types and default lengths; counters are 16 bits so lengths must lie in 1 to 65535 cycles
package prci_cfg_pkg;

  // Width of the filter and hold counters
  localparam int PRCI_CNT_W = 16;

  typedef logic [PRCI_CNT_W-1:0] prci_cnt_t;

  // Reset sequencer states in release order
  typedef enum logic [1:0] {
    ST_WAIT_SYS = 2'd0,
    ST_WAIT_DDR = 2'd1,
    ST_HOLD     = 2'd2,
    ST_RUN      = 2'd3
  } prci_state_e;

  // Cycles a synchronized lock must stay high before it counts as stable
  localparam prci_cnt_t DEF_LOCK_FILTER = prci_cnt_t'(8);

  // Cycles the system reset is held after both locks are qualified
  localparam prci_cnt_t DEF_RESET_HOLD = prci_cnt_t'(16);

endpackage
